/* hw/sd_cmd_pkg.sv */
package sd_cmd_pkg;

    // ============================================================
    // frame layout
    // ============================================================

    // 48-bit command / response frame
    localparam int FRAME_BITS = 48;
    localparam int CRC_BITS = 7;
    // start, transmission, index and argument are covered
    localparam int CRC_COVER_BITS = 40;
    // x^7 + x^3 + 1, top term implied
    localparam logic [CRC_BITS-1:0] CRC7_POLY = 7'h09;

    // ============================================================
    // line timing
    // ============================================================

    // cmd_in forced high while the card takes over the line
    localparam int TURNAROUND_CYCLES = 2;
    // start-bit search window after turnaround
    localparam int RESP_TIMEOUT_CYCLES = 64;

    // one counter width serves bit count, turnaround and timeout
    localparam int CNT_BITS = $clog2(RESP_TIMEOUT_CYCLES > FRAME_BITS ?
                                     RESP_TIMEOUT_CYCLES : FRAME_BITS);
    localparam logic [CNT_BITS-1:0] LAST_BIT_CNT = CNT_BITS'(FRAME_BITS - 1);
    localparam logic [CNT_BITS-1:0] CRC_COVER_CNT = CNT_BITS'(CRC_COVER_BITS);
    // first bit after the crc field, i.e. the end bit
    localparam logic [CNT_BITS-1:0] CRC_OUT_END_CNT = CNT_BITS'(CRC_COVER_BITS + CRC_BITS);
    localparam logic [CNT_BITS-1:0] TURN_LAST_CNT = CNT_BITS'(TURNAROUND_CYCLES - 1);
    localparam logic [CNT_BITS-1:0] TIMEOUT_LAST_CNT = CNT_BITS'(RESP_TIMEOUT_CYCLES - 1);

    // receiver states
    localparam logic [1:0] RX_IDLE = 2'd0;
    localparam logic [1:0] RX_TURN = 2'd1;
    localparam logic [1:0] RX_SEARCH = 2'd2;
    localparam logic [1:0] RX_CAPTURE = 2'd3;

    // ============================================================
    // types
    // ============================================================

    typedef struct packed {
        logic start;
        logic transmission;
        logic [5:0] index;
        logic [31:0] argument;
        logic [CRC_BITS-1:0] crc;
        logic end_bit;
    } sd_frame_fields_t;

    // shifted as raw, checked as fields
    typedef union packed {
        logic [FRAME_BITS-1:0] raw;
        sd_frame_fields_t fields;
    } sd_frame_u;

    typedef struct packed {
        logic [5:0] index;
        logic [31:0] arg;
        logic resp_en;
    } sd_cmd_req_t;

    typedef struct packed {
        logic timeout;
        logic crc_err;
        logic end_err;
    } sd_resp_status_t;

endpackage

/* hw/sd_crc7.sv */
module sd_crc7 (
    input  logic clk_fast,
    input  logic arst_n,
    input  logic clear,
    input  logic shift_en,
    input  logic bit_in,
    output logic [sd_cmd_pkg::CRC_BITS-1:0] crc
);

    logic feedback;

    // msb out xor new bit drives the taps
    assign feedback = bit_in ^ crc[sd_cmd_pkg::CRC_BITS-1];

    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            crc <= '0;
        end else if (clear) begin
            crc <= '0;
        end else if (shift_en) begin
            // shift left, fold polynomial in on feedback
            crc <= {crc[sd_cmd_pkg::CRC_BITS-2:0], 1'b0}
                   ^ (feedback ? sd_cmd_pkg::CRC7_POLY : '0);
        end
    end

endmodule

/* hw/sd_cmd_tx.sv */
module sd_cmd_tx (
    input  logic clk_fast,
    input  logic arst_n,
    input  logic start,
    input  sd_cmd_pkg::sd_cmd_req_t req,
    output logic cmd_out,
    output logic cmd_oe,
    output logic tx_last
);

    sd_cmd_pkg::sd_frame_u frame;
    logic [sd_cmd_pkg::CNT_BITS-1:0] cnt;
    logic [sd_cmd_pkg::CRC_BITS-1:0] crc;
    logic crc_en;
    logic crc_phase;
    logic [2:0] crc_idx;

    // ============================================================
    // bit counter and line enable
    // ============================================================

    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            cmd_oe <= 1'b0;
            cnt <= '0;
            tx_last <= 1'b0;
        end else begin
            tx_last <= 1'b0;
            if (start) begin
                cmd_oe <= 1'b1;
                cnt <= '0;
            end else if (cmd_oe) begin
                cnt <= cnt + 1'b1;
                // end bit goes out this cycle
                if (cnt == sd_cmd_pkg::LAST_BIT_CNT) begin
                    cmd_oe <= 1'b0;
                    tx_last <= 1'b1;
                end
            end
        end
    end

    // frame shifter, msb first
    always_ff @(posedge clk_fast) begin
        if (start) begin
            frame.fields <= '{start: 1'b0, transmission: 1'b1, index: req.index,
                              argument: req.arg, crc: '0, end_bit: 1'b1};
        end else if (cmd_oe) begin
            frame.raw <= {frame.raw[sd_cmd_pkg::FRAME_BITS-2:0], 1'b1};
        end
    end

    // ============================================================
    // crc insertion
    // ============================================================

    // first 40 bits feed the crc
    assign crc_en = cmd_oe && (cnt < sd_cmd_pkg::CRC_COVER_CNT);
    // next 7 bits come from the crc register, msb first
    assign crc_phase = (cnt >= sd_cmd_pkg::CRC_COVER_CNT)
                       && (cnt < sd_cmd_pkg::CRC_OUT_END_CNT);
    assign crc_idx = 3'(sd_cmd_pkg::CRC_OUT_END_CNT - 1'b1 - cnt);

    // idle line is high
    assign cmd_out = !cmd_oe ? 1'b1 : (crc_phase ? crc[crc_idx] : frame.raw[47]);

    sd_crc7 u_crc7 (
        .clk_fast(clk_fast),
        .arst_n(arst_n),
        .clear(start),
        .shift_en(crc_en),
        .bit_in(frame.raw[47]),
        .crc(crc)
    );

endmodule

/* hw/sd_resp_rx.sv */
module sd_resp_rx (
    input  logic clk_fast,
    input  logic arst_n,
    input  logic arm,
    input  logic cmd_in,
    output logic rx_done,
    output sd_cmd_pkg::sd_frame_u resp_data,
    output sd_cmd_pkg::sd_resp_status_t resp_status
);

    logic [1:0] state;
    logic [sd_cmd_pkg::CNT_BITS-1:0] cnt;
    logic start_seen;
    logic shift_en;
    logic crc_en;
    logic [sd_cmd_pkg::CRC_BITS-1:0] crc;
    sd_cmd_pkg::sd_frame_u next_frame;

    // ============================================================
    // capture datapath
    // ============================================================

    // low bit during search is the start bit
    assign start_seen = (state == sd_cmd_pkg::RX_SEARCH) && !cmd_in;
    assign shift_en = start_seen || (state == sd_cmd_pkg::RX_CAPTURE);
    // start bit counts as bit 0 of the crc span
    assign crc_en = start_seen
                    || ((state == sd_cmd_pkg::RX_CAPTURE) && (cnt < sd_cmd_pkg::CRC_COVER_CNT));

    // frame including the bit on the line now
    assign next_frame.raw = {resp_data.raw[sd_cmd_pkg::FRAME_BITS-2:0], cmd_in};

    always_ff @(posedge clk_fast) begin
        if (shift_en) begin
            resp_data <= next_frame;
        end
    end

    sd_crc7 u_crc7 (
        .clk_fast(clk_fast),
        .arst_n(arst_n),
        .clear(arm),
        .shift_en(crc_en),
        .bit_in(cmd_in),
        .crc(crc)
    );

    // ============================================================
    // receive FSM
    // ============================================================

    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            state <= sd_cmd_pkg::RX_IDLE;
            cnt <= '0;
            rx_done <= 1'b0;
            resp_status <= '0;
        end else begin
            rx_done <= 1'b0;
            case (state)
                sd_cmd_pkg::RX_IDLE: begin
                    if (arm) begin
                        // old status dropped at new response
                        resp_status <= '0;
                        cnt <= '0;
                        state <= sd_cmd_pkg::RX_TURN;
                    end
                end
                sd_cmd_pkg::RX_TURN: begin
                    // line still settling, cmd_in not looked at
                    if (cnt == sd_cmd_pkg::TURN_LAST_CNT) begin
                        cnt <= '0;
                        state <= sd_cmd_pkg::RX_SEARCH;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                sd_cmd_pkg::RX_SEARCH: begin
                    if (start_seen) begin
                        // bit 0 already in, next one is bit 1
                        cnt <= 1;
                        state <= sd_cmd_pkg::RX_CAPTURE;
                    end else if (cnt == sd_cmd_pkg::TIMEOUT_LAST_CNT) begin
                        // silent card
                        resp_status.timeout <= 1'b1;
                        rx_done <= 1'b1;
                        state <= sd_cmd_pkg::RX_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                sd_cmd_pkg::RX_CAPTURE: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == sd_cmd_pkg::LAST_BIT_CNT) begin
                        // crc register settled since bit 40
                        resp_status.crc_err <= (next_frame.fields.crc != crc);
                        resp_status.end_err <= !next_frame.fields.end_bit;
                        rx_done <= 1'b1;
                        state <= sd_cmd_pkg::RX_IDLE;
                    end
                end
                default: begin
                    state <= sd_cmd_pkg::RX_IDLE;
                end
            endcase
        end
    end

endmodule

/* hw/sd_cmd_seq.sv */
module sd_cmd_seq (
    input  logic clk_fast,
    input  logic arst_n,
    input  logic cmd_trigger,
    input  sd_cmd_pkg::sd_cmd_req_t req,
    input  logic tx_last,
    input  logic rx_done,
    output logic tx_start,
    output logic rx_arm,
    output logic cmd_done,
    output logic resp_done,
    output logic busy
);

    logic trig_q;
    logic trig_qq;
    logic trig_pulse;

    // ============================================================
    // trigger toggle detect
    // ============================================================

    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            trig_q <= 1'b0;
            trig_qq <= 1'b0;
        end else begin
            trig_q <= cmd_trigger;
            trig_qq <= trig_q;
        end
    end

    // one cycle per toggle, either direction
    assign trig_pulse = trig_q ^ trig_qq;

    // ============================================================
    // command / response sequencing
    // ============================================================

    always_ff @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            tx_start <= 1'b0;
            rx_arm <= 1'b0;
            cmd_done <= 1'b0;
            resp_done <= 1'b0;
            busy <= 1'b0;
        end else begin
            tx_start <= 1'b0;
            rx_arm <= 1'b0;
            // toggles while busy are dropped
            if (trig_pulse && !busy) begin
                busy <= 1'b1;
                tx_start <= 1'b1;
            end
            if (tx_last) begin
                cmd_done <= ~cmd_done;
                // req held stable by host until done
                if (req.resp_en) begin
                    rx_arm <= 1'b1;
                end else begin
                    busy <= 1'b0;
                end
            end
            // response captured or timed out
            if (rx_done) begin
                resp_done <= ~resp_done;
                busy <= 1'b0;
            end
        end
    end

endmodule

/* hw/sd_cmd_ctrl.sv */
module sd_cmd_ctrl (
    input  logic clk_fast,
    input  logic arst_n,
    input  logic cmd_trigger,
    input  sd_cmd_pkg::sd_cmd_req_t cmd_req,
    output logic cmd_done,
    output logic resp_done,
    output sd_cmd_pkg::sd_frame_u resp_data,
    output sd_cmd_pkg::sd_resp_status_t resp_status,
    output logic busy,
    output logic cmd_out,
    output logic cmd_oe,
    input  logic cmd_in
);

    logic tx_start;
    logic tx_last;
    logic rx_arm;
    logic rx_done;

    // ============================================================
    // sequencer
    // ============================================================

    sd_cmd_seq u_seq (
        .clk_fast(clk_fast),
        .arst_n(arst_n),
        .cmd_trigger(cmd_trigger),
        .req(cmd_req),
        .tx_last(tx_last),
        .rx_done(rx_done),
        .tx_start(tx_start),
        .rx_arm(rx_arm),
        .cmd_done(cmd_done),
        .resp_done(resp_done),
        .busy(busy)
    );

    // command out to the card
    sd_cmd_tx u_tx (
        .clk_fast(clk_fast),
        .arst_n(arst_n),
        .start(tx_start),
        .req(cmd_req),
        .cmd_out(cmd_out),
        .cmd_oe(cmd_oe),
        .tx_last(tx_last)
    );

    // response back from the card
    sd_resp_rx u_rx (
        .clk_fast(clk_fast),
        .arst_n(arst_n),
        .arm(rx_arm),
        .cmd_in(cmd_in),
        .rx_done(rx_done),
        .resp_data(resp_data),
        .resp_status(resp_status)
    );

endmodule

/* test/sd_card_model.sv */
module sd_card_model (
    input  logic clk_fast,
    input  logic cmd_out,
    input  logic cmd_oe,
    output logic cmd_in,
    input  sd_cmd_pkg::sd_frame_u resp_frame,
    input  int resp_delay,
    input  logic silent,
    output sd_cmd_pkg::sd_frame_u cmd_frame,
    output int frame_count
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [sd_cmd_pkg::FRAME_BITS-1:0] shift_reg;
    int bit_cnt;
    int i;

    // line sampled and driven on the falling edge
    initial begin
        cmd_in = 1'b1;
        cmd_frame = '0;
        frame_count = 0;
        shift_reg = '0;
        bit_cnt = 0;
        forever begin
            @(negedge clk_fast);
            if (cmd_oe) begin
                // msb first off the host
                shift_reg = {shift_reg[sd_cmd_pkg::FRAME_BITS-2:0], cmd_out};
                bit_cnt++;
            end else if (bit_cnt == sd_cmd_pkg::FRAME_BITS) begin
                // host released the line
                cmd_frame.raw = shift_reg;
                frame_count++;
                bit_cnt = 0;
                if (!silent) begin
                    repeat (resp_delay) @(negedge clk_fast);
                    for (i = sd_cmd_pkg::FRAME_BITS - 1; i >= 0; i--) begin
                        cmd_in = resp_frame.raw[i];
                        @(negedge clk_fast);
                    end
                    // back to idle high
                    cmd_in = 1'b1;
                end
            end
        end
    end

endmodule

/* test/sd_cmd_assertions.sv */
module sd_cmd_assertions (
    input logic clk_fast,
    input logic arst_n,
    input logic cmd_oe,
    input logic cmd_out,
    input logic cmd_done,
    input logic resp_done
);
    timeunit 1ns;
    timeprecision 1ps;

    int oe_cycles;
    int fail_count = 0;

    // length of the current cmd_oe burst
    always @(posedge clk_fast or negedge arst_n) begin
        if (!arst_n) begin
            oe_cycles <= 0;
        end else if (cmd_oe) begin
            oe_cycles <= oe_cycles + 1;
        end else begin
            oe_cycles <= 0;
        end
    end

    // ============================================================
    // line and handshake properties
    // ============================================================

    // burst never runs past one frame
    a_oe_max: assert property (@(posedge clk_fast) disable iff (!arst_n)
        cmd_oe |-> oe_cycles < sd_cmd_pkg::FRAME_BITS)
        else begin
            fail_count++;
            $error("cmd_oe held longer than one frame");
        end

    // and is never cut short
    a_oe_len: assert property (@(posedge clk_fast) disable iff (!arst_n)
        $fell(cmd_oe) |-> oe_cycles == sd_cmd_pkg::FRAME_BITS)
        else begin
            fail_count++;
            $error("cmd_oe burst was %0d cycles", oe_cycles);
        end

    // undriven line idles high
    a_idle_high: assert property (@(posedge clk_fast) disable iff (!arst_n)
        !cmd_oe |-> cmd_out)
        else begin
            fail_count++;
            $error("cmd_out low while cmd_oe low");
        end

    a_done_apart: assert property (@(posedge clk_fast) disable iff (!arst_n)
        !((cmd_done != $past(cmd_done)) && (resp_done != $past(resp_done))))
        else begin
            fail_count++;
            $error("cmd_done and resp_done toggled together");
        end

endmodule

bind sd_cmd_ctrl sd_cmd_assertions u_assertions (
    .clk_fast(clk_fast),
    .arst_n(arst_n),
    .cmd_oe(cmd_oe),
    .cmd_out(cmd_out),
    .cmd_done(cmd_done),
    .resp_done(resp_done)
);

/* test/tb_sd_cmd_ctrl.sv */
module tb_sd_cmd_ctrl;
    timeunit 1ns;
    timeprecision 1ps;

    // ============================================================
    // test table
    // ============================================================

    localparam logic [1:0] MODE_GOOD = 2'd0;
    localparam logic [1:0] MODE_BAD_CRC = 2'd1;
    localparam logic [1:0] MODE_BAD_END = 2'd2;
    localparam logic [1:0] MODE_SILENT = 2'd3;
    localparam int NUM_TESTS = 8;
    // longest path is turnaround + search window + frame
    localparam int WAIT_LIMIT = 300;
    localparam int QUIET_CYCLES = 80;

    typedef struct packed {
        logic [5:0] index;
        logic resp_en;
        logic [6:0] delay;
        logic [1:0] mode;
        logic [5:0] resp_index;
        logic retrigger;
    } test_row_t;

    // index, resp_en, card delay, response mode, response index, second toggle
    // card delays of 4 to 67 land inside the start-bit search window
    localparam test_row_t TESTS [NUM_TESTS] = '{
        '{6'd0, 1'b0, 7'd0, MODE_SILENT, 6'd0, 1'b0},
        '{6'd8, 1'b1, 7'd4, MODE_GOOD, 6'd8, 1'b0},
        '{6'd55, 1'b1, 7'd23, MODE_GOOD, 6'd55, 1'b0},
        '{6'd58, 1'b1, 7'd60, MODE_GOOD, 6'd58, 1'b0},
        '{6'd17, 1'b1, 7'd9, MODE_BAD_CRC, 6'd17, 1'b0},
        '{6'd24, 1'b1, 7'd12, MODE_BAD_END, 6'd24, 1'b0},
        '{6'd13, 1'b1, 7'd0, MODE_SILENT, 6'd0, 1'b0},
        '{6'd16, 1'b1, 7'd30, MODE_GOOD, 6'd16, 1'b1}
    };

    string test_names [NUM_TESTS] = '{"go_idle", "send_if_cond", "app_cmd", "read_ocr",
                                      "bad_crc", "bad_end_bit", "silent_card", "retrigger"};

    logic clk_fast;
    logic arst_n;
    logic cmd_trigger;
    sd_cmd_pkg::sd_cmd_req_t cmd_req;
    logic cmd_done;
    logic resp_done;
    sd_cmd_pkg::sd_frame_u resp_data;
    sd_cmd_pkg::sd_resp_status_t resp_status;
    logic busy;
    logic cmd_out;
    logic cmd_oe;
    logic cmd_in;

    // card side controls and capture
    sd_cmd_pkg::sd_frame_u card_resp;
    int card_delay;
    logic card_silent;
    sd_cmd_pkg::sd_frame_u card_cmd;
    int card_count;
    // last frame the card actually sent back
    sd_cmd_pkg::sd_frame_u held_resp;

    int errors;
    int tests_run;
    int tests_failed;
    logic [15:0] lfsr_state;
    int cmd_toggles = 0;
    int resp_toggles = 0;
    logic cmd_done_q = 1'b0;
    logic resp_done_q = 1'b0;

    sd_cmd_ctrl UUT (
        .clk_fast(clk_fast),
        .arst_n(arst_n),
        .cmd_trigger(cmd_trigger),
        .cmd_req(cmd_req),
        .cmd_done(cmd_done),
        .resp_done(resp_done),
        .resp_data(resp_data),
        .resp_status(resp_status),
        .busy(busy),
        .cmd_out(cmd_out),
        .cmd_oe(cmd_oe),
        .cmd_in(cmd_in)
    );

    sd_card_model card (
        .clk_fast(clk_fast),
        .cmd_out(cmd_out),
        .cmd_oe(cmd_oe),
        .cmd_in(cmd_in),
        .resp_frame(card_resp),
        .resp_delay(card_delay),
        .silent(card_silent),
        .cmd_frame(card_cmd),
        .frame_count(card_count)
    );

    // 20 ns period
    initial begin
        clk_fast = 1'b0;
        forever #10 clk_fast = ~clk_fast;
    end

    // every done edge counted so doubles show up
    always @(negedge clk_fast) begin
        if (cmd_done !== cmd_done_q) cmd_toggles++;
        if (resp_done !== resp_done_q) resp_toggles++;
        cmd_done_q = cmd_done;
        resp_done_q = resp_done;
    end

    // ============================================================
    // reference models
    // ============================================================

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] random_word();
        logic [31:0] w;
        w = '0;
        for (int b = 0; b < 32; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
        return w;
    endfunction

    // long division of msg * x^7 by x^7 + x^3 + 1
    function automatic logic [6:0] crc7_ref(input logic [39:0] msg);
        logic [46:0] rem;
        rem = {msg, 7'b0};
        for (int i = 46; i >= 7; i--) begin
            if (rem[i]) rem[i -: 8] = rem[i -: 8] ^ 8'h89;
        end
        return rem[6:0];
    endfunction

    // ============================================================
    // checks and waits
    // ============================================================

    task automatic check_frame(input string what, input sd_cmd_pkg::sd_frame_u exp,
                               input sd_cmd_pkg::sd_frame_u act);
        if (act !== exp) begin
            $display("ERROR %s: expected %012h, actual %012h", what, exp.raw, act.raw);
            errors++;
        end
    endtask

    task automatic check_status(input string what, input sd_cmd_pkg::sd_resp_status_t exp,
                                input sd_cmd_pkg::sd_resp_status_t act);
        if (act !== exp) begin
            $display("ERROR %s: expected %03b, actual %03b", what, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR %s: expected %b, actual %b", what, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string what, input int exp, input int act);
        if (act != exp) begin
            $display("ERROR %s: expected %0d, actual %0d", what, exp, act);
            errors++;
        end
    endtask

    // sel 0 cmd_done, 1 resp_done, else busy
    task automatic wait_change(input int sel, input logic old_level, input string what);
        int cycles;
        logic level;
        cycles = 0;
        level = old_level;
        while (level === old_level && cycles < WAIT_LIMIT) begin
            @(negedge clk_fast);
            cycles++;
            case (sel)
                0: level = cmd_done;
                1: level = resp_done;
                default: level = busy;
            endcase
        end
        if (level === old_level) begin
            $display("timeout: %s did not change within %0d cycles", what, WAIT_LIMIT);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %-14s ok", name);
        end else begin
            tests_failed++;
            $display("test %-14s fail, %0d errors", name, errors - errors_before);
        end
    endtask

    // ============================================================
    // one table row
    // ============================================================

    task automatic run_row(input int i);
        test_row_t row;
        string name;
        sd_cmd_pkg::sd_cmd_req_t req;
        sd_cmd_pkg::sd_frame_u exp_cmd;
        sd_cmd_pkg::sd_resp_status_t exp_status;
        int errors_before;
        int frames_before;
        int cmd_before;
        int resp_before;
        int cycles;
        row = TESTS[i];
        name = test_names[i];
        errors_before = errors;
        req.index = row.index;
        req.arg = random_word();
        req.resp_en = row.resp_en;
        exp_cmd.fields = '{start: 1'b0, transmission: 1'b1, index: req.index,
                           argument: req.arg, crc: '0, end_bit: 1'b1};
        exp_cmd.fields.crc = crc7_ref(exp_cmd.raw[47:8]);
        // host-bound card reply has transmission 0
        card_resp.fields = '{start: 1'b0, transmission: 1'b0, index: row.resp_index,
                             argument: random_word(), crc: '0, end_bit: 1'b1};
        card_resp.fields.crc = crc7_ref(card_resp.raw[47:8]);
        exp_status = '0;
        if (row.mode == MODE_BAD_CRC) begin
            card_resp.fields.crc[0] = ~card_resp.fields.crc[0];
            exp_status.crc_err = 1'b1;
        end else if (row.mode == MODE_BAD_END) begin
            card_resp.fields.end_bit = 1'b0;
            exp_status.end_err = 1'b1;
        end else if (row.mode == MODE_SILENT) begin
            exp_status.timeout = 1'b1;
        end
        card_delay = int'(row.delay);
        card_silent = (row.mode == MODE_SILENT) || !row.resp_en;
        frames_before = card_count;
        cmd_before = cmd_toggles;
        resp_before = resp_toggles;

        @(negedge clk_fast);
        cmd_req = req;
        cmd_trigger = ~cmd_trigger;
        if (row.retrigger) begin
            // second toggle lands mid frame
            wait_change(2, 1'b0, {name, " busy"});
            repeat (4) @(negedge clk_fast);
            cmd_trigger = ~cmd_trigger;
        end
        wait_change(0, cmd_done, {name, " cmd_done"});
        check_frame({name, " cmd frame"}, exp_cmd, card_cmd);
        if (row.resp_en) begin
            wait_change(1, resp_done, {name, " resp_done"});
            // timeout keeps the previous capture
            if (row.mode == MODE_SILENT) begin
                check_frame({name, " resp_data"}, held_resp, resp_data);
            end else begin
                check_frame({name, " resp_data"}, card_resp, resp_data);
                held_resp = card_resp;
            end
            check_status({name, " resp_status"}, exp_status, resp_status);
        end

        // late or extra activity
        cycles = 0;
        while (cycles < QUIET_CYCLES) begin
            @(negedge clk_fast);
            cycles++;
        end
        check_count({name, " frames"}, 1, card_count - frames_before);
        check_count({name, " cmd_done toggles"}, 1, cmd_toggles - cmd_before);
        check_count({name, " resp_done toggles"}, row.resp_en ? 1 : 0,
                    resp_toggles - resp_before);
        check_bit({name, " busy"}, 1'b0, busy);
        report_test(name, errors_before);
    endtask

    // ============================================================
    // main sequence
    // ============================================================

    initial begin
        int i;
        int errors_before;
        arst_n = 1'b0;
        cmd_trigger = 1'b0;
        cmd_req = '0;
        card_resp = '0;
        card_delay = 0;
        card_silent = 1'b1;
        held_resp = '0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        lfsr_state = 16'd19350;
        repeat (16) @(negedge clk_fast);
        arst_n = 1'b1;
        @(negedge clk_fast);

        // idle state after reset
        errors_before = errors;
        check_bit("reset cmd_oe", 1'b0, cmd_oe);
        check_bit("reset cmd_out", 1'b1, cmd_out);
        check_bit("reset busy", 1'b0, busy);
        check_bit("reset cmd_done", 1'b0, cmd_done);
        check_bit("reset resp_done", 1'b0, resp_done);
        check_status("reset resp_status", '0, resp_status);
        report_test("reset", errors_before);

        for (i = 0; i < NUM_TESTS; i++) begin
            run_row(i);
        end

        if (UUT.u_assertions.fail_count != 0) begin
            $display("bound assertions failed %0d times", UUT.u_assertions.fail_count);
            errors += UUT.u_assertions.fail_count;
        end
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* list.f */
hw/sd_cmd_pkg.sv
hw/sd_crc7.sv
hw/sd_cmd_tx.sv
hw/sd_resp_rx.sv
hw/sd_cmd_seq.sv
hw/sd_cmd_ctrl.sv
test/sd_card_model.sv
test/sd_cmd_assertions.sv
test/tb_sd_cmd_ctrl.sv

/* Makefile */
TOP = tb_sd_cmd_ctrl
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timescale 1ns/1ps --top-module sd_cmd_ctrl \
		hw/sd_cmd_pkg.sv hw/sd_crc7.sv hw/sd_cmd_tx.sv hw/sd_resp_rx.sv \
		hw/sd_cmd_seq.sv hw/sd_cmd_ctrl.sv

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module $(TOP) -f list.f -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+100 2>&1 | tee $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -qF '*** TEST PASSED ***' $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
